// ==== testbench/cpu_controller_testdata.txt ====
# name opcode op cond status(v n z) cycles reg_writes mem_writes branch_load_pc
# status counts on CMP lines only, cycles 0 marks HALT, branch_load_pc -1 when no branch
add              101 00 000 000  8 1 0 -1
and              101 10 000 000  8 1 0 -1
mvn              101 11 000 000  8 1 0 -1
mov_imm          110 10 000 000  5 1 0 -1
mov_shift        110 00 000 000  7 1 0 -1
ldr              011 00 000 000  9 1 0 -1
str              100 00 000 000 10 0 1 -1
illegal_000      000 00 000 000  4 0 0 -1
illegal_010      010 00 000 000  4 0 0 -1
illegal_mov_01   110 01 000 000  4 0 0 -1
illegal_mov_11   110 11 000 000  4 0 0 -1
beq_cleared      001 00 001 000  5 0 0 0
b_always         001 00 000 000  5 0 0 1
cmp_equal        101 01 000 001  7 0 0 -1
str_between      100 00 000 000 10 0 1 -1
beq_equal        001 00 001 000  5 0 0 1
bne_equal        001 00 010 000  5 0 0 0
ble_equal        001 00 100 000  5 0 0 1
cmp_less         101 01 000 010  7 0 0 -1
blt_less         001 00 011 000  5 0 0 1
bne_less         001 00 010 000  5 0 0 1
cmp_overflow     101 01 000 110  7 0 0 -1
ldr_between      011 00 000 000  9 1 0 -1
blt_overflow     001 00 011 000  5 0 0 0
ble_overflow     001 00 100 000  5 0 0 0
b_unused_cond    001 00 101 000  5 0 0 0
cmp_equal_2      101 01 000 001  7 0 0 -1
halt             111 00 000 000  0 0 0 -1
beq_after_reset  001 00 001 000  5 0 0 0
mov_after_reset  110 10 000 000  5 1 0 -1

// ==== vlog.f ====
rtl/cpu_ctrl_pkg.sv
rtl/instr_decoder.sv
rtl/branch_resolver.sv
rtl/controller_fsm.sv
rtl/control_decoder.sv
rtl/cpu_controller.sv
testbench/tb_cpu_controller.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cpu_controller
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_cpu_controller.sv ====
/* Testbench for the CPU sequencing controller
   Runs instruction vectors from the data file, checks sequencing and strobes */
`timescale 1ns/10ps

module tb_cpu_controller;

	localparam int TIMEOUT = 40;	// Cycles per wait

	logic                         clk;
	logic                         reset;
	cpu_ctrl_pkg::opcode_t        opcode;
	cpu_ctrl_pkg::alu_op_t        op;
	cpu_ctrl_pkg::cond_t          cond;
	cpu_ctrl_pkg::status_t        alu_status;
	cpu_ctrl_pkg::datapath_ctrl_t datapath_ctrl;
	cpu_ctrl_pkg::memory_ctrl_t   memory_ctrl;
	cpu_ctrl_pkg::state_t         state;

	int    errors;
	int    checks;
	string test_name;

	cpu_controller dut (
		.clk           (clk),
		.reset         (reset),
		.opcode        (opcode),
		.op            (op),
		.cond          (cond),
		.alu_status    (alu_status),
		.datapath_ctrl (datapath_ctrl),
		.memory_ctrl   (memory_ctrl),
		.state         (state)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic abort_run(input string why);
		$display("Run stopped in %s: %s", test_name, why);
		$display("%0d errors in %0d checks", errors, checks);
		$display("Checks failed");
		$finish;
	endtask

	// Returns at the first falling edge that shows the target state
	task automatic wait_state(input cpu_ctrl_pkg::state_t target);
		int n;
		n = 0;
		while (state != target) begin
			n++;
			if (n > TIMEOUT)
				abort_run($sformatf("timeout waiting for %s", target.name()));
			@(negedge clk);
		end
	endtask

	task automatic apply_inputs(input cpu_ctrl_pkg::opcode_t o, input cpu_ctrl_pkg::alu_op_t p,
		input cpu_ctrl_pkg::cond_t c, input cpu_ctrl_pkg::status_t s);
		@(posedge clk);
		opcode     <= o;
		op         <= p;
		cond       <= c;
		alu_status <= s;
	endtask

	task automatic do_reset();
		int n;
		@(posedge clk);
		reset <= 1'b1;
		for (n = 0; n < 5; n++) begin
			@(negedge clk);
			if (n > 0) begin	// State register settles after the first edge
				check_value("reset state", int'(cpu_ctrl_pkg::S_RESET), int'(state));
				check_value("reset load_pc", 1, int'(memory_ctrl.load_pc));
				check_value("reset pc_sel", int'(cpu_ctrl_pkg::PC_ZERO), int'(memory_ctrl.pc_sel));
				check_value("reset write", 0, int'(datapath_ctrl.write));
				check_value("reset load_s", 0, int'(datapath_ctrl.load_s));
				check_value("reset load_ir", 0, int'(memory_ctrl.load_ir));
				check_value("reset mem_cmd", int'(cpu_ctrl_pkg::MEM_READ),
					int'(memory_ctrl.mem_cmd));
			end
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		wait_state(cpu_ctrl_pkg::S_IF1);
	endtask

	// One instruction from S_IF1 to the next S_IF1
	task automatic run_instr(input cpu_ctrl_pkg::opcode_t o, input cpu_ctrl_pkg::alu_op_t p,
		input cpu_ctrl_pkg::cond_t c, input cpu_ctrl_pkg::status_t s,
		input int exp_cycles, input int exp_writes, input int exp_mem_writes,
		input int exp_branch);
		int n;
		int cycles;
		int writes;
		int mem_writes;
		int ir_loads;
		int branch_pc;
		int branch_sel;
		cycles = 0;
		writes = 0;
		mem_writes = 0;
		ir_loads = 0;
		branch_pc = -1;
		branch_sel = -1;
		wait_state(cpu_ctrl_pkg::S_IF1);
		for (n = 1; n <= TIMEOUT; n++) begin
			cycles++;
			writes += int'(datapath_ctrl.write);
			mem_writes += int'(memory_ctrl.mem_cmd == cpu_ctrl_pkg::MEM_WRITE);
			ir_loads += int'(memory_ctrl.load_ir);
			if (state == cpu_ctrl_pkg::S_BRANCH) begin
				branch_pc = int'(memory_ctrl.load_pc);
				branch_sel = int'(memory_ctrl.pc_sel);
			end
			if (n == 1)
				apply_inputs(o, p, c, s);	// Fetch states ignore the fields
			@(negedge clk);
			if (state == cpu_ctrl_pkg::S_IF1)
				break;
		end
		if (state != cpu_ctrl_pkg::S_IF1)
			abort_run("no return to S_IF1 within the timeout");
		check_value("cycles", exp_cycles, cycles);
		check_value("register writes", exp_writes, writes);
		check_value("memory writes", exp_mem_writes, mem_writes);
		check_value("load_ir cycles", 1, ir_loads);
		check_value("branch load_pc", exp_branch, branch_pc);
		if (exp_branch >= 0)
			check_value("branch pc_sel", (exp_branch == 1) ? int'(cpu_ctrl_pkg::PC_BRANCH)
				: int'(cpu_ctrl_pkg::PC_INC), branch_sel);
	endtask

	task automatic run_halt(input cpu_ctrl_pkg::opcode_t o, input cpu_ctrl_pkg::alu_op_t p,
		input cpu_ctrl_pkg::cond_t c, input cpu_ctrl_pkg::status_t s);
		int n;
		wait_state(cpu_ctrl_pkg::S_IF1);
		apply_inputs(o, p, c, s);
		@(negedge clk);
		wait_state(cpu_ctrl_pkg::S_HALT);
		for (n = 0; n < 20; n++) begin
			@(negedge clk);
			check_value("halt state", int'(cpu_ctrl_pkg::S_HALT), int'(state));
			check_value("halt write", 0, int'(datapath_ctrl.write));
			check_value("halt MEM_WRITE", 0,
				int'(memory_ctrl.mem_cmd == cpu_ctrl_pkg::MEM_WRITE));
		end
		do_reset();	// Only way out of S_HALT
	endtask

	initial begin
		int         fd;
		int         fields;
		int         cycles;
		int         writes;
		int         mem_writes;
		int         branch;
		string      line;
		string      name;
		logic [2:0] f_opcode;
		logic [1:0] f_op;
		logic [2:0] f_cond;
		logic [2:0] f_status;
		errors = 0;
		checks = 0;
		test_name = "reset";
		reset = 1'b1;
		opcode = 3'b000;
		op = 2'b00;
		cond = 3'b000;
		alu_status = '0;
		void'($urandom(32'hc427));
		fd = $fopen("testbench/cpu_controller_testdata.txt", "r");
		if (fd == 0)
			abort_run("cannot open testbench/cpu_controller_testdata.txt");
		do_reset();
		while ($fgets(line, fd) > 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			fields = $sscanf(line, "%s %b %b %b %b %d %d %d %d", name, f_opcode, f_op, f_cond,
				f_status, cycles, writes, mem_writes, branch);
			if (fields != 9)
				abort_run("malformed line in the data file");
			test_name = name;
			// Random status on every line but CMP
			if (!(f_opcode == cpu_ctrl_pkg::OPC_ALU && f_op == cpu_ctrl_pkg::OP_CMP))
				f_status = 3'($urandom());
			if (cycles == 0)
				run_halt(f_opcode, f_op, f_cond, f_status);
			else
				run_instr(f_opcode, f_op, f_cond, f_status, cycles, writes, mem_writes, branch);
		end
		$fclose(fd);
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== rtl/cpu_controller.sv ====
/* CPU sequencing controller top level
   Connects the decoder, FSM, control decoder and branch resolver */
`timescale 1ns/10ps

module cpu_controller (
	input  logic                         clk,
	input  logic                         reset,
	input  cpu_ctrl_pkg::opcode_t        opcode,
	input  cpu_ctrl_pkg::alu_op_t        op,
	input  cpu_ctrl_pkg::cond_t          cond,
	input  cpu_ctrl_pkg::status_t        alu_status,
	output cpu_ctrl_pkg::datapath_ctrl_t datapath_ctrl,
	output cpu_ctrl_pkg::memory_ctrl_t   memory_ctrl,
	output cpu_ctrl_pkg::state_t         state
);

	cpu_ctrl_pkg::instr_class_t instr_class;
	logic                       take_branch;

	instr_decoder u_instr_decoder (
		.opcode      (opcode),
		.op          (op),
		.instr_class (instr_class)
	);

	controller_fsm u_controller_fsm (
		.clk         (clk),
		.reset       (reset),
		.instr_class (instr_class),
		.state       (state)
	);

	control_decoder u_control_decoder (
		.state         (state),
		.take_branch   (take_branch),
		.datapath_ctrl (datapath_ctrl),
		.memory_ctrl   (memory_ctrl)
	);

	// Flags captured on the CMP strobe
	branch_resolver u_branch_resolver (
		.clk         (clk),
		.reset       (reset),
		.cond        (cond),
		.alu_status  (alu_status),
		.load_s      (datapath_ctrl.load_s),
		.take_branch (take_branch)
	);

endmodule

// ==== rtl/control_decoder.sv ====
/* Control decoder
   Turns the current state into datapath and memory control words */
`timescale 1ns/10ps

module control_decoder (
	input  cpu_ctrl_pkg::state_t         state,
	input  logic                         take_branch,
	output cpu_ctrl_pkg::datapath_ctrl_t datapath_ctrl,
	output cpu_ctrl_pkg::memory_ctrl_t   memory_ctrl
);

	always_comb begin
		datapath_ctrl = cpu_ctrl_pkg::DP_IDLE;
		memory_ctrl   = cpu_ctrl_pkg::MEM_IDLE;
		case (state)
			cpu_ctrl_pkg::S_RESET: begin
				memory_ctrl.load_pc = 1'b1;
				memory_ctrl.pc_sel  = cpu_ctrl_pkg::PC_ZERO;
			end
			cpu_ctrl_pkg::S_IF1: memory_ctrl.addr_sel = 1'b1;	// Address from PC
			cpu_ctrl_pkg::S_IF2: begin
				memory_ctrl.addr_sel = 1'b1;
				memory_ctrl.load_ir  = 1'b1;
			end
			cpu_ctrl_pkg::S_UPDATE_PC: memory_ctrl.load_pc = 1'b1;	// PC + 1

			// Operand fetch for ALU and CMP
			cpu_ctrl_pkg::S_GET_A: begin
				datapath_ctrl.load_a = 1'b1;
				datapath_ctrl.nsel   = cpu_ctrl_pkg::REG_RN;
			end
			cpu_ctrl_pkg::S_GET_B: begin
				datapath_ctrl.load_b = 1'b1;
				datapath_ctrl.nsel   = cpu_ctrl_pkg::REG_RM;
			end
			cpu_ctrl_pkg::S_ALU: datapath_ctrl.load_c = 1'b1;
			cpu_ctrl_pkg::S_CMP: begin
				datapath_ctrl.load_c = 1'b1;
				datapath_ctrl.load_s = 1'b1;
			end
			cpu_ctrl_pkg::S_WRITE_RES: begin
				datapath_ctrl.write = 1'b1;
				datapath_ctrl.nsel  = cpu_ctrl_pkg::REG_RD;
				datapath_ctrl.vsel  = cpu_ctrl_pkg::WB_C;
			end

			cpu_ctrl_pkg::S_MOVE: begin	// Rn = sx(im8)
				datapath_ctrl.write = 1'b1;
				datapath_ctrl.nsel  = cpu_ctrl_pkg::REG_RN;
				datapath_ctrl.vsel  = cpu_ctrl_pkg::WB_IMM;
			end
			cpu_ctrl_pkg::S_MOVE_SHIFT: begin
				datapath_ctrl.load_b = 1'b1;
				datapath_ctrl.nsel   = cpu_ctrl_pkg::REG_RM;
			end
			cpu_ctrl_pkg::S_MOVE_SHIFT2: begin
				datapath_ctrl.load_c = 1'b1;
				datapath_ctrl.asel   = 1'b1;	// 0 + shifted B
			end

			// Address is Rn + sx(im5) for both LDR and STR
			cpu_ctrl_pkg::S_LDR_GET_A, cpu_ctrl_pkg::S_STR_GET_A: begin
				datapath_ctrl.load_a = 1'b1;
				datapath_ctrl.nsel   = cpu_ctrl_pkg::REG_RN;
			end
			cpu_ctrl_pkg::S_LDR_ADD, cpu_ctrl_pkg::S_STR_ADD: begin
				datapath_ctrl.load_c = 1'b1;
				datapath_ctrl.bsel   = 1'b1;
			end
			cpu_ctrl_pkg::S_LDR_LOAD_ADDR, cpu_ctrl_pkg::S_STR_LOAD_ADDR:
				memory_ctrl.load_addr = 1'b1;
			cpu_ctrl_pkg::S_READ_RAM: begin
				datapath_ctrl.nsel = cpu_ctrl_pkg::REG_RD;
				datapath_ctrl.vsel = cpu_ctrl_pkg::WB_MDATA;
			end
			cpu_ctrl_pkg::S_LOAD_MDATA: begin
				datapath_ctrl.write = 1'b1;
				datapath_ctrl.nsel  = cpu_ctrl_pkg::REG_RD;
				datapath_ctrl.vsel  = cpu_ctrl_pkg::WB_MDATA;
			end
			cpu_ctrl_pkg::S_STR_GET_B: begin
				datapath_ctrl.load_b = 1'b1;
				datapath_ctrl.nsel   = cpu_ctrl_pkg::REG_RD;	// Store data from Rd
			end
			cpu_ctrl_pkg::S_STR_DPATH: begin
				datapath_ctrl.load_c = 1'b1;
				datapath_ctrl.asel   = 1'b1;
			end
			cpu_ctrl_pkg::S_WRITE_RAM: memory_ctrl.mem_cmd = cpu_ctrl_pkg::MEM_WRITE;

			cpu_ctrl_pkg::S_BRANCH: begin
				memory_ctrl.load_pc = take_branch;
				memory_ctrl.pc_sel  = take_branch ? cpu_ctrl_pkg::PC_BRANCH
					: cpu_ctrl_pkg::PC_INC;
			end
			cpu_ctrl_pkg::S_HALT: memory_ctrl.mem_cmd = cpu_ctrl_pkg::MEM_NONE;	// Bus quiet
			default: ;
		endcase
	end

	// Register file and memory never written in the same state
	always_comb begin
		a_no_double_write: assert (!(datapath_ctrl.write &&
			memory_ctrl.mem_cmd == cpu_ctrl_pkg::MEM_WRITE))
			else $error("register write and MEM_WRITE together");
	end

endmodule

// ==== rtl/controller_fsm.sv ====
/* Controller FSM
   Fetch sequence and per-class state patterns, one state per clock */
`timescale 1ns/10ps

module controller_fsm (
	input  logic                       clk,
	input  logic                       reset,
	input  cpu_ctrl_pkg::instr_class_t instr_class,
	output cpu_ctrl_pkg::state_t       state
);

	cpu_ctrl_pkg::state_t next_state;

	always_ff @(posedge clk) begin
		if (reset)
			state <= cpu_ctrl_pkg::S_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = cpu_ctrl_pkg::S_IF1;	// End of every pattern
		case (state)
			cpu_ctrl_pkg::S_RESET:     next_state = cpu_ctrl_pkg::S_IF1;
			cpu_ctrl_pkg::S_IF1:       next_state = cpu_ctrl_pkg::S_IF2;
			cpu_ctrl_pkg::S_IF2:       next_state = cpu_ctrl_pkg::S_UPDATE_PC;
			cpu_ctrl_pkg::S_UPDATE_PC: next_state = cpu_ctrl_pkg::S_DECODE;
			cpu_ctrl_pkg::S_DECODE: begin
				case (instr_class)
					cpu_ctrl_pkg::CLS_ALU,
					cpu_ctrl_pkg::CLS_CMP:        next_state = cpu_ctrl_pkg::S_GET_A;
					cpu_ctrl_pkg::CLS_MOVE_IMM:   next_state = cpu_ctrl_pkg::S_MOVE;
					cpu_ctrl_pkg::CLS_MOVE_SHIFT: next_state = cpu_ctrl_pkg::S_MOVE_SHIFT;
					cpu_ctrl_pkg::CLS_LOAD:       next_state = cpu_ctrl_pkg::S_LDR_GET_A;
					cpu_ctrl_pkg::CLS_STORE:      next_state = cpu_ctrl_pkg::S_STR_GET_A;
					cpu_ctrl_pkg::CLS_BRANCH:     next_state = cpu_ctrl_pkg::S_BRANCH;
					cpu_ctrl_pkg::CLS_HALT:       next_state = cpu_ctrl_pkg::S_HALT;
					default:                      next_state = cpu_ctrl_pkg::S_IF1;
				endcase
			end

			// ALU and CMP share operand fetch
			cpu_ctrl_pkg::S_GET_A: next_state = cpu_ctrl_pkg::S_GET_B;
			cpu_ctrl_pkg::S_GET_B: begin
				if (instr_class == cpu_ctrl_pkg::CLS_CMP)
					next_state = cpu_ctrl_pkg::S_CMP;	// Flags only and no writeback
				else
					next_state = cpu_ctrl_pkg::S_ALU;
			end
			cpu_ctrl_pkg::S_ALU:         next_state = cpu_ctrl_pkg::S_WRITE_RES;
			cpu_ctrl_pkg::S_MOVE_SHIFT:  next_state = cpu_ctrl_pkg::S_MOVE_SHIFT2;
			cpu_ctrl_pkg::S_MOVE_SHIFT2: next_state = cpu_ctrl_pkg::S_WRITE_RES;

			// LDR
			cpu_ctrl_pkg::S_LDR_GET_A:     next_state = cpu_ctrl_pkg::S_LDR_ADD;
			cpu_ctrl_pkg::S_LDR_ADD:       next_state = cpu_ctrl_pkg::S_LDR_LOAD_ADDR;
			cpu_ctrl_pkg::S_LDR_LOAD_ADDR: next_state = cpu_ctrl_pkg::S_READ_RAM;
			cpu_ctrl_pkg::S_READ_RAM:      next_state = cpu_ctrl_pkg::S_LOAD_MDATA;

			// STR
			cpu_ctrl_pkg::S_STR_GET_A:     next_state = cpu_ctrl_pkg::S_STR_ADD;
			cpu_ctrl_pkg::S_STR_ADD:       next_state = cpu_ctrl_pkg::S_STR_LOAD_ADDR;
			cpu_ctrl_pkg::S_STR_LOAD_ADDR: next_state = cpu_ctrl_pkg::S_STR_GET_B;
			cpu_ctrl_pkg::S_STR_GET_B:     next_state = cpu_ctrl_pkg::S_STR_DPATH;
			cpu_ctrl_pkg::S_STR_DPATH:     next_state = cpu_ctrl_pkg::S_WRITE_RAM;

			cpu_ctrl_pkg::S_HALT: next_state = cpu_ctrl_pkg::S_HALT;	// Only reset leaves
			default:              next_state = cpu_ctrl_pkg::S_IF1;
		endcase
	end

	a_halt_sticky: assert property (
		@(posedge clk) disable iff (reset)
		state == cpu_ctrl_pkg::S_HALT |=> state == cpu_ctrl_pkg::S_HALT
	) else $error("left S_HALT without reset");

endmodule

// ==== rtl/branch_resolver.sv ====
/* Branch resolver
   Holds the status flags captured by CMP and evaluates the branch condition */
`timescale 1ns/10ps

module branch_resolver (
	input  logic                  clk,
	input  logic                  reset,
	input  cpu_ctrl_pkg::cond_t   cond,
	input  cpu_ctrl_pkg::status_t alu_status,
	input  logic                  load_s,
	output logic                  take_branch
);

	cpu_ctrl_pkg::status_t flags;

	always_ff @(posedge clk) begin
		if (reset)
			flags <= '0;
		else if (load_s)
			flags <= alu_status;	// Visible from the next cycle
	end

	always_comb begin
		case (cond)
			cpu_ctrl_pkg::COND_B:   take_branch = 1'b1;
			cpu_ctrl_pkg::COND_BEQ: take_branch = flags.z;
			cpu_ctrl_pkg::COND_BNE: take_branch = ~flags.z;
			cpu_ctrl_pkg::COND_BLT: take_branch = flags.n ^ flags.v;
			// Less than or equal
			cpu_ctrl_pkg::COND_BLE: take_branch = (flags.n ^ flags.v) | flags.z;
			default:                take_branch = 1'b0;
		endcase
	end

	// Flags come out of reset cleared, so the decision must stay known
	a_take_branch_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(take_branch)
	) else $error("take_branch is unknown");

endmodule

// ==== rtl/instr_decoder.sv ====
/* Instruction decoder
   Sorts the opcode and op fields into one instruction class */
`timescale 1ns/10ps

module instr_decoder (
	input  cpu_ctrl_pkg::opcode_t      opcode,
	input  cpu_ctrl_pkg::alu_op_t      op,
	output cpu_ctrl_pkg::instr_class_t instr_class
);

	always_comb begin
		case (opcode)
			cpu_ctrl_pkg::OPC_ALU: begin
				if (op == cpu_ctrl_pkg::OP_CMP)
					instr_class = cpu_ctrl_pkg::CLS_CMP;
				else
					instr_class = cpu_ctrl_pkg::CLS_ALU;	// ADD, AND, MVN
			end
			cpu_ctrl_pkg::OPC_MOVE: begin
				case (op)
					cpu_ctrl_pkg::OP_MOV_SHIFT: instr_class = cpu_ctrl_pkg::CLS_MOVE_SHIFT;
					cpu_ctrl_pkg::OP_MOV_IMM:   instr_class = cpu_ctrl_pkg::CLS_MOVE_IMM;
					default:                    instr_class = cpu_ctrl_pkg::CLS_ILLEGAL;
				endcase
			end
			cpu_ctrl_pkg::OPC_LOAD:   instr_class = cpu_ctrl_pkg::CLS_LOAD;
			cpu_ctrl_pkg::OPC_STORE:  instr_class = cpu_ctrl_pkg::CLS_STORE;
			cpu_ctrl_pkg::OPC_BRANCH: instr_class = cpu_ctrl_pkg::CLS_BRANCH;
			cpu_ctrl_pkg::OPC_HALT:   instr_class = cpu_ctrl_pkg::CLS_HALT;
			// Link and exchange group lands here too
			default:                  instr_class = cpu_ctrl_pkg::CLS_ILLEGAL;
		endcase
	end

endmodule

// ==== rtl/cpu_ctrl_pkg.sv ====
/* Shared types for the CPU sequencing controller
   Instruction fields, controller states, instruction classes and control words */
package cpu_ctrl_pkg;

	typedef logic [2:0] opcode_t;	// Major opcode field
	typedef logic [1:0] alu_op_t;	// Op field
	typedef logic [2:0] cond_t;	// Branch condition field

	// Major opcodes
	localparam opcode_t OPC_BRANCH = 3'b001;
	localparam opcode_t OPC_LOAD   = 3'b011;
	localparam opcode_t OPC_STORE  = 3'b100;
	localparam opcode_t OPC_ALU    = 3'b101;
	localparam opcode_t OPC_MOVE   = 3'b110;
	localparam opcode_t OPC_HALT   = 3'b111;

	localparam alu_op_t OP_CMP       = 2'b01;
	localparam alu_op_t OP_MOV_SHIFT = 2'b00;
	localparam alu_op_t OP_MOV_IMM   = 2'b10;

	// Branch conditions
	localparam cond_t COND_B   = 3'b000;
	localparam cond_t COND_BEQ = 3'b001;
	localparam cond_t COND_BNE = 3'b010;
	localparam cond_t COND_BLT = 3'b011;
	localparam cond_t COND_BLE = 3'b100;

	typedef enum logic [4:0] {
		S_RESET, S_IF1, S_IF2, S_UPDATE_PC, S_DECODE,
		S_GET_A, S_GET_B, S_ALU, S_CMP, S_WRITE_RES,
		S_MOVE, S_MOVE_SHIFT, S_MOVE_SHIFT2,
		S_LDR_GET_A, S_LDR_ADD, S_LDR_LOAD_ADDR, S_READ_RAM, S_LOAD_MDATA,
		S_STR_GET_A, S_STR_ADD, S_STR_LOAD_ADDR, S_STR_GET_B, S_STR_DPATH, S_WRITE_RAM,
		S_BRANCH, S_HALT
	} state_t;

	typedef enum logic [3:0] {
		CLS_ALU, CLS_CMP, CLS_MOVE_IMM, CLS_MOVE_SHIFT, CLS_LOAD,
		CLS_STORE, CLS_BRANCH, CLS_HALT, CLS_ILLEGAL
	} instr_class_t;

	// One-hot register number select
	typedef enum logic [2:0] {
		REG_RN = 3'b001,
		REG_RM = 3'b010,
		REG_RD = 3'b100
	} reg_sel_t;

	// One-hot register file writeback select
	typedef enum logic [3:0] {
		WB_C     = 4'b0001,
		WB_PC    = 4'b0010,
		WB_IMM   = 4'b0100,
		WB_MDATA = 4'b1000
	} wb_sel_t;

	typedef enum logic [1:0] {
		MEM_NONE  = 2'b00,
		MEM_READ  = 2'b01,
		MEM_WRITE = 2'b10
	} mem_cmd_t;

	typedef enum logic [1:0] {PC_ZERO, PC_INC, PC_BRANCH} pc_sel_t;

	typedef struct packed {
		logic v;	// Overflow
		logic n;	// Negative
		logic z;	// Zero
	} status_t;

	typedef struct packed {
		logic     load_a;
		logic     load_b;
		logic     load_c;
		logic     load_s;	// Capture ALU status
		logic     asel;	// Zero in place of A
		logic     bsel;	// Immediate in place of B
		logic     write;	// Register file write
		reg_sel_t nsel;
		wb_sel_t  vsel;
	} datapath_ctrl_t;

	typedef struct packed {
		mem_cmd_t mem_cmd;
		logic     addr_sel;	// 1 selects PC as address
		logic     load_addr;
		logic     load_ir;
		logic     load_pc;
		pc_sel_t  pc_sel;
	} memory_ctrl_t;

	// Idle control words that each state builds on
	localparam datapath_ctrl_t DP_IDLE = '{
		load_a: 1'b0, load_b: 1'b0, load_c: 1'b0, load_s: 1'b0,
		asel: 1'b0, bsel: 1'b0, write: 1'b0, nsel: REG_RN, vsel: WB_C
	};
	localparam memory_ctrl_t MEM_IDLE = '{
		mem_cmd: MEM_READ, addr_sel: 1'b0, load_addr: 1'b0,
		load_ir: 1'b0, load_pc: 1'b0, pc_sel: PC_INC
	};

endpackage
